/* hw/gmii_pkg.sv */
package gmii_pkg;

	//////////////////////
	// GMII transmit side

	// One beat of the MAC transmit bus
	typedef struct packed {
		// TX_EN
		logic       en;
		// TX_ER
		logic       er;
		// TXD
		logic [7:0] data;
	} gmii_tx_t;

	// Preamble octet, first byte of every frame
	localparam logic [7:0] GMII_PREAMBLE = 8'h55;

endpackage

/* hw/pcs_pkg.sv */
package pcs_pkg;

	//////////////////////
	// Code-group level types

	// One octet toward the 8b/10b encoder
	typedef struct packed {
		// K code-group when set, D otherwise
		logic       is_ctl;
		logic [7:0] data;
	} code_group_t;

	// Mode and advertised abilities
	typedef struct packed {
		logic        an_enable;
		logic        sgmii_mode;
		logic [15:0] ability;
	} pcs_cfg_t;

	//////////////////////
	// Special code-group octets

	// Comma, leads every ordered set
	localparam logic [7:0] K28_5 = 8'hbc;
	// Second octet of /C1/
	localparam logic [7:0] D21_5 = 8'hb5;
	// Second octet of /C2/
	localparam logic [7:0] D2_2  = 8'h42;
	// Second octet of /I2/
	localparam logic [7:0] D16_2 = 8'h50;
	// Start, end, carrier extend, error
	localparam logic [7:0] K27_7 = 8'hfb;
	localparam logic [7:0] K29_7 = 8'hfd;
	localparam logic [7:0] K23_7 = 8'hf7;
	localparam logic [7:0] K30_7 = 8'hfe;

	//////////////////////
	// Autoneg and registers

	// MAC side SGMII config word
	localparam logic [15:0] SGMII_CFG_WORD = 16'h4001;
	// Acknowledge bit in the config word
	localparam int ACK_BIT = 14;

	// Register map
	localparam logic [1:0] REG_CTRL    = 2'd0;
	localparam logic [1:0] REG_ABILITY = 2'd1;
	// Control register bits
	localparam int CTRL_AN_ENABLE = 0;
	localparam int CTRL_SGMII     = 1;
	localparam int CTRL_RESTART   = 2;
	// Values after reset, full duplex advertised
	localparam logic [15:0] CTRL_RESET    = 16'h0001;
	localparam logic [15:0] ABILITY_RESET = 16'h0020;

	// Forced config after restart, short for simulation
	localparam int LINK_TIMER_CYCLES = 64;
	localparam int LINK_TIMER_W      = $clog2(LINK_TIMER_CYCLES + 1);

endpackage

/* hw/pcs_tx_autoneg.sv */
`timescale 1ns/10ps

module pcs_tx_autoneg (
	input  logic              tx_clk,
	input  logic              rst,
	input  pcs_pkg::pcs_cfg_t cfg,
	input  logic              an_restart,
	// Levels from the receive side
	input  logic              an_complete,
	input  logic              partner_ack,
	// End of each config set, from the encapsulator
	input  logic              cfg_set_done,
	// Config sets wanted on the line
	output logic              cfg_active,
	output logic [15:0]       cfg_word,
	// Low for /C1/, high for /C2/
	output logic              c2_next
);

	import pcs_pkg::*;

	// Cycles of forced config left
	logic [LINK_TIMER_W-1:0] link_timer;
	logic                    timer_run;

	assign timer_run = (link_timer != '0);

	//////////////////////
	// Link timer

	// Restart reloads, otherwise count down to zero and hold
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			link_timer <= '0;
		end else if (an_restart) begin
			link_timer <= LINK_TIMER_W'(LINK_TIMER_CYCLES);
		end else if (timer_run) begin
			link_timer <= link_timer - 1'b1;
		end
	end

	//////////////////////
	// Config mode

	// Registered so it is low in the first cycle after reset
	// Stays up until autoneg completes and the timer expires
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			cfg_active <= 1'b0;
		end else begin
			cfg_active <= cfg.an_enable && (!an_complete || timer_run);
		end
	end

	//////////////////////
	// Config word

	// Encapsulator latches this at the start of a set
	always_comb begin
		if (cfg.sgmii_mode) begin
			cfg_word = SGMII_CFG_WORD;
		end else begin
			cfg_word = cfg.ability;
			// Ack follows the partner, not the register
			cfg_word[ACK_BIT] = partner_ack;
		end
	end

	//////////////////////
	// /C1/ /C2/ sequencing

	// First set after reset is /C1/
	// Toggle on every finished set so the two strictly alternate
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			c2_next <= 1'b0;
		end else if (cfg_set_done) begin
			c2_next <= ~c2_next;
		end
	end

endmodule

/* hw/pcs_tx_ctrl_regs.sv */
`timescale 1ns/10ps

module pcs_tx_ctrl_regs (
	input  logic              tx_clk,
	input  logic              rst,
	// Single-cycle write strobe
	input  logic              reg_wr,
	input  logic [1:0]        reg_addr,
	input  logic [15:0]       reg_wdata,
	// Mode and abilities toward autoneg and encapsulator
	output pcs_pkg::pcs_cfg_t cfg,
	// One pulse per restart request
	output logic              an_restart
);

	import pcs_pkg::*;

	// Address decode
	logic wr_ctrl;
	logic wr_ability;

	assign wr_ctrl    = reg_wr && (reg_addr == REG_CTRL);
	assign wr_ability = reg_wr && (reg_addr == REG_ABILITY);

	//////////////////////
	// Control register

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			cfg.an_enable  <= CTRL_RESET[CTRL_AN_ENABLE];
			cfg.sgmii_mode <= CTRL_RESET[CTRL_SGMII];
		end else if (wr_ctrl) begin
			cfg.an_enable  <= reg_wdata[CTRL_AN_ENABLE];
			cfg.sgmii_mode <= reg_wdata[CTRL_SGMII];
		end
	end

	//////////////////////
	// Ability register

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			cfg.ability <= ABILITY_RESET;
		end else if (wr_ability) begin
			cfg.ability <= reg_wdata;
		end
	end

	//////////////////////
	// Restart strobe

	// Restart bit is never stored
	// Pulse lasts exactly one cycle after the write
	always_ff @(posedge tx_clk) begin
		if (rst) begin
			an_restart <= 1'b0;
		end else begin
			an_restart <= wr_ctrl && reg_wdata[CTRL_RESTART];
		end
	end

	// Addresses 2 and 3 are unmapped, writes there are dropped

endmodule

/* hw/pcs_tx_encap.sv */
`timescale 1ns/10ps

module pcs_tx_encap (
	input  logic                 tx_clk,
	input  logic                 rst,
	input  gmii_pkg::gmii_tx_t   gmii_tx,
	// Config request and word from autoneg
	input  logic                 cfg_active,
	input  logic [15:0]          cfg_word,
	input  logic                 c2_next,
	// High with the last octet of each config set
	output logic                 cfg_set_done,
	output pcs_pkg::code_group_t pcs_tx
);

	import gmii_pkg::*;
	import pcs_pkg::*;

	typedef enum logic [2:0] {
		ST_IDLE,
		ST_CONFIG,
		ST_START,
		ST_DATA,
		ST_END,
		ST_EXTEND
	} state_t;

	// GMII delay line, stage 0 is the input register
	gmii_tx_t    dly [3];
	// Data source for the frame body
	gmii_tx_t    tap;
	logic        frame_start;

	state_t      state;
	state_t      nxt_state;
	// Parity of the octet now on pcs_tx
	logic        slot_odd;
	logic        next_even;
	// Octet index inside a config set
	logic [1:0]  oct;
	logic [1:0]  nxt_oct;
	// Frame started one slot late, body comes from stage 2
	logic        slip;
	logic        nxt_slip;
	logic        nxt_done;
	logic        capture;
	code_group_t nxt_cg;
	// Config word held for the whole set
	logic [15:0] word_q;

	function automatic code_group_t make_cg(input logic ctl, input logic [7:0] octet);
		code_group_t c;
		c.is_ctl = ctl;
		c.data   = octet;
		return c;
	endfunction

	//////////////////////
	// Delay line

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			dly[0] <= '0;
			dly[1] <= '0;
			dly[2] <= '0;
		end else begin
			dly[0] <= gmii_tx;
			dly[1] <= dly[0];
			dly[2] <= dly[1];
		end
	end

	// Rising tx_en seen at stage 1
	assign frame_start = dly[1].en && !dly[2].en;
	assign tap         = slip ? dly[2] : dly[1];
	// Next octet lands on an ordered-set boundary
	assign next_even   = slot_odd;

	//////////////////////
	// Next octet

	always_comb begin
		nxt_cg    = make_cg(1'b1, K28_5);
		nxt_state = state;
		nxt_oct   = oct;
		nxt_slip  = slip;
		nxt_done  = 1'b0;
		capture   = 1'b0;
		case (state)
			ST_IDLE: begin
				if (next_even) begin
					if (cfg_active) begin
						// Config wins, a frame rising now is lost
						nxt_state = ST_CONFIG;
						nxt_oct   = 2'd1;
						capture   = 1'b1;
					end else if (frame_start) begin
						// /S/ over the first preamble octet
						nxt_cg    = make_cg(1'b1, K27_7);
						nxt_slip  = 1'b0;
						nxt_state = ST_DATA;
					end
				end else begin
					// Finish the /I2/ before any start
					nxt_cg = make_cg(1'b0, D16_2);
					if (frame_start) begin
						nxt_slip  = 1'b1;
						nxt_state = ST_START;
					end
				end
			end
			ST_CONFIG: begin
				nxt_oct = oct + 2'd1;
				case (oct)
					// c2_next has already toggled by now
					2'd1: nxt_cg = make_cg(1'b0, c2_next ? D2_2 : D21_5);
					2'd2: nxt_cg = make_cg(1'b0, word_q[7:0]);
					default: begin
						nxt_cg    = make_cg(1'b0, word_q[15:8]);
						nxt_done  = 1'b1;
						nxt_state = ST_IDLE;
					end
				endcase
			end
			// Delayed /S/, preamble octet now sits in stage 2
			ST_START: begin
				nxt_cg    = make_cg(1'b1, K27_7);
				nxt_state = ST_DATA;
			end
			ST_DATA: begin
				if (tap.en) begin
					// Errored beat goes out as /V/
					if (tap.er) begin
						nxt_cg = make_cg(1'b1, K30_7);
					end else begin
						nxt_cg = make_cg(1'b0, tap.data);
					end
				end else begin
					nxt_cg    = make_cg(1'b1, K29_7);
					nxt_state = ST_END;
				end
			end
			ST_END: begin
				// /R/ on even slot needs a second one
				nxt_cg    = make_cg(1'b1, K23_7);
				nxt_slip  = 1'b0;
				nxt_state = next_even ? ST_EXTEND : ST_IDLE;
			end
			ST_EXTEND: begin
				nxt_cg    = make_cg(1'b1, K23_7);
				nxt_state = ST_IDLE;
			end
			default: begin
				nxt_state = ST_IDLE;
			end
		endcase
	end

	//////////////////////
	// Output and control registers

	always_ff @(posedge tx_clk) begin
		if (rst) begin
			pcs_tx       <= make_cg(1'b1, K28_5);
			slot_odd     <= 1'b0;
			state        <= ST_IDLE;
			oct          <= 2'd0;
			slip         <= 1'b0;
			cfg_set_done <= 1'b0;
		end else begin
			pcs_tx       <= nxt_cg;
			slot_odd     <= ~slot_odd;
			state        <= nxt_state;
			oct          <= nxt_oct;
			slip         <= nxt_slip;
			cfg_set_done <= nxt_done;
		end
	end

	// Word latched with the comma so a set is never torn
	always_ff @(posedge tx_clk) begin
		if (capture) begin
			word_q <= cfg_word;
		end
	end

endmodule

/* hw/pcs_tx_top.sv */
`timescale 1ns/10ps

module pcs_tx_top (
	input  logic                 tx_clk,
	input  logic                 rst,
	// Register write port
	input  logic                 reg_wr,
	input  logic [1:0]           reg_addr,
	input  logic [15:0]          reg_wdata,
	// MAC transmit bus
	input  gmii_pkg::gmii_tx_t   gmii_tx,
	// Results from the receive side
	input  logic                 partner_ack,
	input  logic                 an_complete,
	// Toward the 8b/10b encoder
	output pcs_pkg::code_group_t pcs_tx
);

	import pcs_pkg::*;

	pcs_cfg_t    cfg;
	logic        an_restart;
	logic        cfg_active;
	logic [15:0] cfg_word;
	logic        c2_next;
	logic        cfg_set_done;

	//////////////////////
	// Registers

	pcs_tx_ctrl_regs i_regs (
		.tx_clk     (tx_clk),
		.rst        (rst),
		.reg_wr     (reg_wr),
		.reg_addr   (reg_addr),
		.reg_wdata  (reg_wdata),
		.cfg        (cfg),
		.an_restart (an_restart)
	);

	//////////////////////
	// Autoneg transmit side

	pcs_tx_autoneg i_autoneg (
		.tx_clk       (tx_clk),
		.rst          (rst),
		.cfg          (cfg),
		.an_restart   (an_restart),
		.an_complete  (an_complete),
		.partner_ack  (partner_ack),
		.cfg_set_done (cfg_set_done),
		.cfg_active   (cfg_active),
		.cfg_word     (cfg_word),
		.c2_next      (c2_next)
	);

	//////////////////////
	// Encapsulator, owns output alignment

	pcs_tx_encap i_encap (
		.tx_clk       (tx_clk),
		.rst          (rst),
		.gmii_tx      (gmii_tx),
		.cfg_active   (cfg_active),
		.cfg_word     (cfg_word),
		.c2_next      (c2_next),
		.cfg_set_done (cfg_set_done),
		.pcs_tx       (pcs_tx)
	);

endmodule

/* list.f */
hw/gmii_pkg.sv
hw/pcs_pkg.sv
hw/pcs_tx_ctrl_regs.sv
hw/pcs_tx_autoneg.sv
hw/pcs_tx_encap.sv
hw/pcs_tx_top.sv
verification/pcs_tx_assertions.sv
verification/pcs_tx_checker.sv
verification/pcs_tx_tb.sv

/* verification/pcs_tx_assertions.sv */
`timescale 1ns/10ps

module pcs_tx_assertions (
	input logic                 tx_clk,
	input logic                 rst,
	input logic                 slot_odd,
	input pcs_pkg::code_group_t pcs_tx
);

	import pcs_pkg::*;

	// Failure count, read by the testbench
	int failures = 0;

	// Comma only ever opens an ordered set
	comma_even: assert property (@(posedge tx_clk) disable iff (rst)
		(pcs_tx.is_ctl && pcs_tx.data == K28_5) |-> !slot_odd)
	else begin
		$error("K28_5 on an odd slot");
		failures++;
	end

	// /S/ takes the place of the comma
	start_even: assert property (@(posedge tx_clk) disable iff (rst)
		(pcs_tx.is_ctl && pcs_tx.data == K27_7) |-> !slot_odd)
	else begin
		$error("/S/ on an odd slot");
		failures++;
	end

	// Reset leaves the first /I2/ octet on an even slot
	reset_idle: assert property (@(posedge tx_clk)
		rst |=> (pcs_tx.is_ctl && pcs_tx.data == K28_5 && !slot_odd))
	else begin
		$error("pcs_tx is not the /I2/ comma after reset");
		failures++;
	end

endmodule

bind pcs_tx_encap pcs_tx_assertions i_assertions (
	.tx_clk   (tx_clk),
	.rst      (rst),
	.slot_odd (slot_odd),
	.pcs_tx   (pcs_tx)
);

/* verification/pcs_tx_checker.sv */
`timescale 1ns/10ps

module pcs_tx_checker (
	input  logic                 tx_clk,
	input  logic                 rst,
	input  logic                 reg_wr,
	input  logic [1:0]           reg_addr,
	input  logic [15:0]          reg_wdata,
	input  gmii_pkg::gmii_tx_t   gmii_tx,
	input  logic                 partner_ack,
	input  logic                 an_complete,
	input  pcs_pkg::code_group_t pcs_tx,
	// Results for the testbench
	output int                   errors,
	output int                   pending,
	output int                   cfg_sets,
	output int                   idle_sets
);

	import gmii_pkg::*;
	import pcs_pkg::*;

	// Cycles a mode change needs to reach the line
	localparam int SETTLE = 12;

	typedef enum {P_SET, P_SECOND, P_LOW, P_HIGH, P_DATA, P_EXT, P_SYNC} parse_t;

	// Register shadow built from the write port
	logic        sh_en;
	logic        sh_sgmii;
	logic [15:0] sh_ability;
	int          restart_left;
	// Config mode model and cycles since it last changed
	logic        mode;
	logic        mode_q;
	int          stable;
	// Sent beats with bit 10 marking the first of a frame
	logic [10:0] beats[$];
	logic        was_en;
	logic        dropping;
	// Output parser
	parse_t      pst;
	logic        odd;
	logic        c2_exp;
	logic [15:0] word_prev;
	logic [15:0] word_cur;

	function automatic code_group_t code_group(input logic ctl, input logic [7:0] octet);
		code_group_t c;
		c.is_ctl = ctl;
		c.data   = octet;
		return c;
	endfunction

	////////////////////
	// Reference functions

	// Word a config set should carry
	function automatic logic [15:0] expected_word(input logic sgmii, input logic [15:0] ability,
		input logic ack);
		logic [15:0] w;
		w          = ability;
		w[ACK_BIT] = ack;
		return sgmii ? SGMII_CFG_WORD : w;
	endfunction

	// Line octet for one sent body beat
	function automatic code_group_t expected_octet(input logic [10:0] ent);
		if (ent[8]) begin
			return code_group(1'b1, K30_7);
		end
		return code_group(1'b0, ent[7:0]);
	endfunction

	task automatic report_fault(input string msg);
		$display("%s at %0t", msg, $time);
		errors++;
		pst = P_SYNC;
	endtask

	task automatic check_octet(input string what, input code_group_t exp);
		if (pcs_tx !== exp) begin
			$display("Mismatch pcs_tx %s at %0t: expected %h, got %h", what, $time, exp, pcs_tx);
			errors++;
			pst = P_SYNC;
		end
	endtask

	////////////////////
	// Ordered set parser

	task automatic parse_octet();
		case (pst)
			P_SYNC: begin
				// Resync on the next even comma
				if (!odd && pcs_tx === code_group(1'b1, K28_5)) begin
					word_cur = word_prev;
					pst      = P_SECOND;
				end
			end
			P_SET: begin
				if (odd) begin
					report_fault("Ordered set started on an odd slot");
				end else if (pcs_tx === code_group(1'b1, K28_5)) begin
					word_cur = word_prev;
					pst      = P_SECOND;
				end else if (pcs_tx === code_group(1'b1, K27_7)) begin
					if (mode && stable >= SETTLE) begin
						report_fault("Frame started during configuration");
					end else if (beats.size() == 0 || !beats[0][10]) begin
						report_fault("Frame on pcs_tx with none pending");
					end else begin
						void'(beats.pop_front());
						pst = P_DATA;
					end
				end else begin
					check_octet("set start", code_group(1'b1, K28_5));
				end
			end
			P_SECOND: begin
				if (pcs_tx === code_group(1'b0, D16_2)) begin
					pst = P_SET;
					idle_sets++;
					if (mode && stable >= SETTLE) begin
						report_fault("Idle sent during configuration");
					end
				end else begin
					pst = P_LOW;
					if (!mode && stable >= SETTLE) begin
						report_fault("Config set sent outside configuration");
					end else begin
						check_octet("config set type", code_group(1'b0, c2_exp ? D2_2 : D21_5));
					end
					// /C1/ and /C2/ alternate
					c2_exp = !c2_exp;
				end
			end
			P_LOW: begin
				pst = P_HIGH;
				check_octet("config word low", code_group(1'b0, word_cur[7:0]));
			end
			P_HIGH: begin
				pst = P_SET;
				cfg_sets++;
				check_octet("config word high", code_group(1'b0, word_cur[15:8]));
			end
			P_DATA: begin
				if (beats.size() != 0 && !beats[0][10]) begin
					check_octet("frame octet", expected_octet(beats.pop_front()));
				end else begin
					pst = P_EXT;
					check_octet("end delimiter", code_group(1'b1, K29_7));
				end
			end
			default: begin
				// Second /R/ only when the first was even
				pst = odd ? P_SET : P_EXT;
				check_octet("carrier extend", code_group(1'b1, K23_7));
			end
		endcase
	endtask

	////////////////////
	// Compare process

	always @(posedge tx_clk) begin
		if (rst) begin
			// Autoneg on and full duplex advertised after reset
			sh_en        = 1'b1;
			sh_sgmii     = 1'b0;
			sh_ability   = 16'h0020;
			restart_left = 0;
			mode_q       = 1'b0;
			stable       = 0;
			beats.delete();
			was_en       = 1'b0;
			dropping     = 1'b0;
			pst          = P_SET;
			odd          = 1'b0;
			c2_exp       = 1'b0;
			word_prev    = expected_word(sh_sgmii, sh_ability, partner_ack);
		end else begin
			mode = sh_en && (!an_complete || restart_left != 0);
			stable = (mode == mode_q) ? stable + 1 : 0;
			mode_q = mode;
			// Frames rising in config never reach the line
			if (gmii_tx.en) begin
				if (!was_en) begin
					dropping = mode;
				end
				if (!dropping) begin
					beats.push_back({!was_en, gmii_tx});
				end
			end
			was_en = gmii_tx.en;
			parse_octet();
			odd = !odd;
			// Word the DUT latches if a comma goes out now
			word_prev = expected_word(sh_sgmii, sh_ability, partner_ack);
			if (restart_left != 0) begin
				restart_left--;
			end
			if (reg_wr && reg_addr == REG_CTRL) begin
				sh_en    = reg_wdata[CTRL_AN_ENABLE];
				sh_sgmii = reg_wdata[CTRL_SGMII];
				if (reg_wdata[CTRL_RESTART]) begin
					restart_left = LINK_TIMER_CYCLES;
				end
			end
			if (reg_wr && reg_addr == REG_ABILITY) begin
				sh_ability = reg_wdata;
			end
			pending = beats.size();
		end
	end

endmodule

/* verification/pcs_tx_tb.sv */
`timescale 1ns/10ps

module pcs_tx_tb;

	import gmii_pkg::*;
	import pcs_pkg::*;

	// Cycle bound on every wait
	localparam int WAIT_LIMIT = 2000;

	logic        tx_clk;
	logic        rst;
	logic        reg_wr;
	logic [1:0]  reg_addr;
	logic [15:0] reg_wdata;
	gmii_tx_t    gmii_tx;
	logic        partner_ack;
	logic        an_complete;
	code_group_t pcs_tx;

	int chk_errors;
	int pending;
	int cfg_sets;
	int idle_sets;
	int tb_errors;
	int total;

	pcs_tx_top i_dut (
		.tx_clk      (tx_clk),
		.rst         (rst),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.gmii_tx     (gmii_tx),
		.partner_ack (partner_ack),
		.an_complete (an_complete),
		.pcs_tx      (pcs_tx)
	);

	pcs_tx_checker i_checker (
		.tx_clk      (tx_clk),
		.rst         (rst),
		.reg_wr      (reg_wr),
		.reg_addr    (reg_addr),
		.reg_wdata   (reg_wdata),
		.gmii_tx     (gmii_tx),
		.partner_ack (partner_ack),
		.an_complete (an_complete),
		.pcs_tx      (pcs_tx),
		.errors      (chk_errors),
		.pending     (pending),
		.cfg_sets    (cfg_sets),
		.idle_sets   (idle_sets)
	);

	initial begin
		tx_clk = 1'b0;
		forever #4 tx_clk = ~tx_clk;
	end

	task automatic write_reg(input logic [1:0] addr, input logic [15:0] data);
		@(negedge tx_clk);
		reg_wr    = 1'b1;
		reg_addr  = addr;
		reg_wdata = data;
		@(negedge tx_clk);
		reg_wr    = 1'b0;
	endtask

	// Wait for n more config or idle sets on the line
	task automatic wait_sets(input logic want_cfg, input int n);
		int target;
		int cycles;
		target = (want_cfg ? cfg_sets : idle_sets) + n;
		cycles = 0;
		while ((want_cfg ? cfg_sets : idle_sets) < target && cycles < WAIT_LIMIT) begin
			@(negedge tx_clk);
			cycles++;
		end
		if ((want_cfg ? cfg_sets : idle_sets) < target) begin
			$display("Timeout waiting for %0d %s sets", n, want_cfg ? "config" : "idle");
			tb_errors++;
		end
	endtask

	task automatic wait_drained();
		int cycles;
		cycles = 0;
		while (pending != 0 && cycles < WAIT_LIMIT) begin
			@(negedge tx_clk);
			cycles++;
		end
		if (pending != 0) begin
			$display("Timeout waiting for %0d frame beats to leave the DUT", pending);
			tb_errors++;
		end
	endtask

	////////////////////
	// Frame generation

	// Preamble first, err_pos below zero means a clean frame
	task automatic send_frame(input int len, input int err_pos);
		int i;
		for (i = 0; i < len; i++) begin
			@(negedge tx_clk);
			gmii_tx.en   = 1'b1;
			gmii_tx.er   = (i == err_pos);
			gmii_tx.data = (i == 0) ? GMII_PREAMBLE : 8'($urandom);
		end
		@(negedge tx_clk);
		gmii_tx = '0;
		// Interframe gap, never under 12
		repeat (12 + $urandom_range(0, 8)) @(negedge tx_clk);
	endtask

	task automatic random_frames(input int count);
		int k;
		int len;
		int err;
		for (k = 0; k < count; k++) begin
			len = $urandom_range(8, 40);
			// Odd frames carry one errored beat
			err = (k % 2) ? $urandom_range(1, len - 1) : -1;
			send_frame(len, err);
		end
	endtask

	initial begin
		void'($urandom(1));
		rst         = 1'b1;
		reg_wr      = 1'b0;
		reg_addr    = '0;
		reg_wdata   = '0;
		gmii_tx     = '0;
		partner_ack = 1'b0;
		an_complete = 1'b0;
		tb_errors   = 0;
		repeat (16) @(negedge tx_clk);
		rst = 1'b0;

		// Reset ability word, then acknowledged
		wait_sets(1'b1, 3);
		partner_ack = 1'b1;
		wait_sets(1'b1, 3);
		// New ability, then SGMII word, then back
		write_reg(REG_ABILITY, 16'h01a0);
		wait_sets(1'b1, 3);
		write_reg(REG_CTRL, 16'h0003);
		wait_sets(1'b1, 3);
		write_reg(REG_CTRL, 16'h0001);
		wait_sets(1'b1, 3);
		// Dropped while config runs
		send_frame(16, 5);
		wait_sets(1'b1, 2);

		////////////////////
		// Link up

		an_complete = 1'b1;
		wait_sets(1'b0, 4);
		random_frames(8);
		// Restart forces config for the link timer
		write_reg(REG_CTRL, 16'h0005);
		wait_sets(1'b1, 4);
		wait_sets(1'b0, 4);
		random_frames(4);
		// Autoneg off, idles even with the link down
		write_reg(REG_CTRL, 16'h0000);
		an_complete = 1'b0;
		wait_sets(1'b0, 4);
		random_frames(4);
		wait_drained();
		wait_sets(1'b0, 2);

		total = chk_errors + tb_errors + i_dut.i_encap.i_assertions.failures;
		$display("Errors: checker %0d, testbench %0d, assertions %0d", chk_errors, tb_errors,
			i_dut.i_encap.i_assertions.failures);
		if (total == 0) begin
			$display("Regression passed");
		end else begin
			$display("Regression failed");
		end
		$finish;
	end

endmodule
